// ==== list.f ====
+incdir+logic
+incdir+verification
logic/bottomPkg.sv
logic/microDecode.sv
logic/registerFile.sv
logic/addressUnit.sv
logic/operandShaper.sv
logic/resultWriteback.sv
logic/bottomDatapath.sv
verification/bottomTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --timescale 1ns/1ps -Wno-fatal --top-module bottomTb \
	-f list.f -o bottomSim \
	&& ./obj_dir/bottomSim > sim.log 2>&1 \
	|| echo "Build or simulation did not complete"
cat sim.log 2>/dev/null
grep -qx "Testbench passed" sim.log \
	&& echo "Simulation passed" \
	|| { echo "Simulation failed"; exit 1; }

// ==== verification/bottomModel.svh ====
`ifndef BOTTOM_MODEL_SVH
`define BOTTOM_MODEL_SVH

logic [`BOTTOM_DATA_W-1:0] mRegs [0:10];	// B C D E H L A W Z SPH SPL
logic [`BOTTOM_ADDR_W-1:0] mPc;
logic [`BOTTOM_DATA_W-1:0] mIr;
uopT exUop;	// Micro-op in its execute cycle

function automatic int pairHi(input logic [1:0] p);
	return (p == 2'd3) ? int'(REG_SPH) : 2 * int'(p);
endfunction

function automatic int pairLo(input logic [1:0] p);
	return (p == 2'd3) ? int'(REG_SPL) : 2 * int'(p) + 1;
endfunction

function automatic logic [`BOTTOM_ADDR_W-1:0] pairValue(input logic [1:0] p);
	return {mRegs[pairHi(p)], mRegs[pairLo(p)]};
endfunction

// bc[4] blanks everything, bc[0] gates the per-bit clears of the top nibble
function automatic logic [`BOTTOM_DATA_W-1:0] maskOf(input logic [5:0] bc);
	logic [`BOTTOM_DATA_W-1:0] m;
	m = bc[4] ? 8'hFF : 8'h00;
	if (bc[0]) begin
		if (bc[1]) m[4] = 1'b1;
		if (bc[5]) m[5] = 1'b1;
		if (bc[2]) m[6] = 1'b1;
		if (bc[3]) m[7] = 1'b1;
	end
	return m;
endfunction

function automatic logic [`BOTTOM_ADDR_W-1:0] predictAddr(input uopT u);
	return (u.kind == PAIRSTEP) ? pairValue(u.dst[1:0]) : mPc;
endfunction

function automatic logic [`BOTTOM_DATA_W-1:0] predictOp1(input uopT u);
	return (u.kind == ALUOP) ? mRegs[REG_A] : `BOTTOM_IDLE_OPERAND;
endfunction

function automatic logic [`BOTTOM_DATA_W-1:0] predictOp2(input uopT u);
	return (u.kind == ALUOP) ? (mRegs[u.src] & ~maskOf(u.bc)) : `BOTTOM_IDLE_OPERAND;
endfunction

// Order is bq4, bq5, bq7
function automatic logic [2:0] predictStatus();
	logic [7:0] a;
	a = mRegs[REG_A];
	return {|a[3:1], |a[7:5], a[4] | a[7]};
endfunction

function automatic logic [3:0] predictFlags();
	return mRegs[REG_Z][7:4];
endfunction

// Writes that land at the edge closing the execute cycle
function automatic void applyUop(input uopT u, input logic [7:0] r, input logic [4:0] vec);
	logic [`BOTTOM_ADDR_W-1:0] p;
	case (u.kind)
		LOADIMM: mRegs[u.dst] = u.imm;
		MOVE: mRegs[u.dst] = mRegs[u.src];
		ALUOP: begin
			mRegs[REG_A] = r;
			mRegs[REG_Z] = r;
		end
		FETCH: begin
			mIr = u.imm;
			mPc = mPc + 16'd1;
		end
		PAIRSTEP: begin
			p = u.down ? pairValue(u.dst[1:0]) - 16'd1 : pairValue(u.dst[1:0]) + 16'd1;
			mRegs[pairHi(u.dst[1:0])] = p[15:8];
			mRegs[pairLo(u.dst[1:0])] = p[7:0];
		end
		JUMP: mPc = {mRegs[REG_W], mRegs[REG_Z]};
		RESTART: mPc = {8'd0, vec, 3'b000};	// Vector times eight
		default: begin
		end
	endcase
endfunction

`endif

// ==== verification/bottomTb.sv ====
`include "bottom_defines.svh"

module bottomTb
	import bottomPkg::*;
();
	timeunit 1ns;
	timeprecision 1ps;

	localparam int Period = 40;
	localparam int ResetCycles = 3;
	localparam logic [31:0] Seed = 32'h78b6cbeb;
	localparam int RegUops = 44;
	localparam int AluUops = 40;
	localparam int PairUops = 24;
	localparam int FlowUops = 13;
	localparam int MixUops = 400;
	localparam int TotalUops = 1 + RegUops + AluUops + PairUops + FlowUops + MixUops + 2;

	logic CLK;
	logic rstN;
	logic uopValid;
	uopT uop;
	logic [`BOTTOM_DATA_W-1:0] res;
	logic [`BOTTOM_VECTOR_W-1:0] irqVector;
	logic [`BOTTOM_ADDR_W-1:0] addr;
	logic [`BOTTOM_DATA_W-1:0] aluOp1;
	logic [`BOTTOM_DATA_W-1:0] aluOp2;
	logic bq4;
	logic bq5;
	logic bq7;
	flagsT tempFlags;
	logic [`BOTTOM_DATA_W-1:0] ir;

	logic [31:0] lfsrState;
	int checkCount;
	int errorCount;
	int testErrors;

	`include "bottomModel.svh"

	bottomDatapath dut0 (
		.CLK(CLK), .rstN(rstN), .uopValid(uopValid), .uop(uop), .res(res),
		.irqVector(irqVector), .addr(addr), .aluOp1(aluOp1), .aluOp2(aluOp2),
		.bq4(bq4), .bq5(bq5), .bq7(bq7), .tempFlags(tempFlags), .ir(ir)
	);

	initial begin
		CLK = 1'b0;
		forever #(Period / 2) CLK = ~CLK;
	end

	// Taps 32, 22, 2, 1
	function automatic logic [31:0] randBits(input int n);
		logic [31:0] r;
		logic fb;
		r = '0;
		for (int i = 0; i < n; i++) begin
			fb = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
			lfsrState = {lfsrState[30:0], fb};
			r = {r[30:0], fb};
		end
		return r;
	endfunction

	function automatic regIdxT pickReg();
		return regIdxT'(4'(randBits(4) % 11));
	endfunction

	function automatic uopT makeUop(input uopKindT k, input regIdxT d, input regIdxT s,
			input logic [7:0] imm, input logic dn, input logic [5:0] bc);
		uopT u;
		u.kind = k;
		u.dst = d;
		u.src = s;
		u.imm = imm;
		u.down = dn;
		u.bc = bc;
		return u;
	endfunction

	function automatic uopT randomUop();
		uopKindT k;
		k = uopKindT'(3'(randBits(3)));
		return makeUop(k, pickReg(), pickReg(), 8'(randBits(8)), randBits(1) != 0, 6'(randBits(6)));
	endfunction

	task automatic checkValue(input string name, input logic [31:0] got, input logic [31:0] exp);
		checkCount++;
		if (got !== exp) begin
			errorCount++;
			testErrors++;
			$display("CHECK FAILED %s: got %0h, expected %0h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic finishTest(input string name);
		$display("%s finished with %0d errors", name, testErrors);
		testErrors = 0;
	endtask

	// Compare, then feed res and the next uop, one cycle per call
	task automatic stepCycle(input uopT u, input logic valid);
		logic [7:0] r;
		logic [4:0] v;
		checkValue("addr", 32'(addr), 32'(predictAddr(exUop)));
		checkValue("aluOp1", 32'(aluOp1), 32'(predictOp1(exUop)));
		checkValue("aluOp2", 32'(aluOp2), 32'(predictOp2(exUop)));
		checkValue("bq4,bq5,bq7", 32'({bq4, bq5, bq7}), 32'(predictStatus()));
		checkValue("tempFlags", 32'(tempFlags), 32'(predictFlags()));
		checkValue("ir", 32'(ir), 32'(mIr));
		r = 8'(randBits(8));
		v = 5'(randBits(5));
		res = r;
		irqVector = v;
		applyUop(exUop, r, v);
		uop = u;
		uopValid = valid;
		exUop = valid ? u : makeUop(NOP, REG_B, REG_B, 8'd0, 1'b0, 6'd0);
		@(negedge CLK);
	endtask

	task automatic sweepRegisters();
		for (int r = 0; r < 11; r++) begin
			stepCycle(makeUop(LOADIMM, regIdxT'(4'(r)), REG_B, 8'(randBits(8)), 1'b0, 6'd0), 1'b1);
		end
		for (int r = 0; r < 11; r++) begin
			stepCycle(makeUop(ALUOP, REG_A, regIdxT'(4'(r)), 8'd0, 1'b0, 6'd0), 1'b1);
		end
		for (int r = 0; r < 11; r++) begin
			stepCycle(makeUop(MOVE, regIdxT'(4'(r)), regIdxT'(4'((r + 3) % 11)), 8'd0, 1'b0, 6'd0),
				1'b1);
			stepCycle(makeUop(ALUOP, REG_A, regIdxT'(4'(r)), 8'd0, 1'b0, 6'd0), 1'b1);
		end
		finishTest("register sweep");
	endtask

	task automatic walkPairs();
		regIdxT hi;
		regIdxT lo;
		regIdxT sel;
		for (int p = 0; p < 4; p++) begin
			hi = (p == 3) ? REG_SPH : regIdxT'(4'(2 * p));
			lo = (p == 3) ? REG_SPL : regIdxT'(4'(2 * p + 1));
			sel = regIdxT'(4'(p));	// Low two bits select the pair
			stepCycle(makeUop(LOADIMM, hi, REG_B, 8'hFF, 1'b0, 6'd0), 1'b1);
			stepCycle(makeUop(LOADIMM, lo, REG_B, 8'hFF, 1'b0, 6'd0), 1'b1);
			stepCycle(makeUop(PAIRSTEP, sel, REG_B, 8'd0, 1'b0, 6'd0), 1'b1);	// FFFF wraps up
			stepCycle(makeUop(PAIRSTEP, sel, REG_B, 8'd0, 1'b1, 6'd0), 1'b1);	// 0000 wraps down
			stepCycle(makeUop(PAIRSTEP, sel, REG_B, 8'd0, 1'b1, 6'd0), 1'b1);
			stepCycle(makeUop(PAIRSTEP, sel, REG_B, 8'd0, 1'b0, 6'd0), 1'b1);
		end
		finishTest("pair step");
	endtask

	task automatic followProgramFlow();
		repeat (3) stepCycle(makeUop(FETCH, REG_B, REG_B, 8'(randBits(8)), 1'b0, 6'd0), 1'b1);
		stepCycle(makeUop(LOADIMM, REG_W, REG_B, 8'(randBits(8)), 1'b0, 6'd0), 1'b1);
		stepCycle(makeUop(LOADIMM, REG_Z, REG_B, 8'(randBits(8)), 1'b0, 6'd0), 1'b1);
		stepCycle(makeUop(JUMP, REG_B, REG_B, 8'd0, 1'b0, 6'd0), 1'b1);
		repeat (2) stepCycle(makeUop(FETCH, REG_B, REG_B, 8'(randBits(8)), 1'b0, 6'd0), 1'b1);
		stepCycle(makeUop(RESTART, REG_B, REG_B, 8'd0, 1'b0, 6'd0), 1'b1);
		repeat (2) stepCycle(makeUop(FETCH, REG_B, REG_B, 8'(randBits(8)), 1'b0, 6'd0), 1'b1);
		repeat (2) stepCycle(makeUop(NOP, REG_B, REG_B, 8'd0, 1'b0, 6'd0), 1'b1);
		finishTest("program flow");
	endtask

	initial begin
		#(TotalUops * 2 * Period + ResetCycles * Period);
		$display("Watchdog expired before the tests finished");
		$display("Testbench failed");
		$finish;
	end

	initial begin
		uopValid = 1'b0;
		uop = '0;
		res = '0;
		irqVector = '0;
		rstN = 1'b0;
		lfsrState = Seed;
		checkCount = 0;
		errorCount = 0;
		testErrors = 0;
		for (int i = 0; i < 11; i++) mRegs[i] = '0;
		mPc = '0;
		mIr = '0;
		exUop = makeUop(NOP, REG_B, REG_B, 8'd0, 1'b0, 6'd0);
		repeat (ResetCycles) @(negedge CLK);
		rstN = 1'b1;

		// Fixed values straight out of reset
		checkValue("addr", 32'(addr), 32'h0);
		checkValue("ir", 32'(ir), 32'h0);
		checkValue("aluOp1", 32'(aluOp1), 32'hFF);
		checkValue("aluOp2", 32'(aluOp2), 32'hFF);
		checkValue("tempFlags", 32'(tempFlags), 32'h0);
		checkValue("bq4,bq5,bq7", 32'({bq4, bq5, bq7}), 32'h0);
		stepCycle(makeUop(NOP, REG_B, REG_B, 8'd0, 1'b0, 6'd0), 1'b0);
		finishTest("reset");

		sweepRegisters();
		repeat (AluUops) begin
			stepCycle(makeUop(ALUOP, REG_A, pickReg(), 8'd0, 1'b0, 6'(randBits(6))), 1'b1);
		end
		finishTest("operand mask");
		walkPairs();
		followProgramFlow();
		repeat (MixUops) stepCycle(randomUop(), randBits(2) != 0);	// About one in four dropped
		repeat (2) stepCycle(makeUop(NOP, REG_B, REG_B, 8'd0, 1'b0, 6'd0), 1'b0);
		finishTest("mixed stream");

		$display("Checks run: %0d, errors: %0d", checkCount, errorCount);
		if (errorCount == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

// ==== logic/bottomDatapath.sv ====
`include "bottom_defines.svh"

module bottomDatapath
	import bottomPkg::*;
(
	input logic CLK,
	input logic rstN,
	input logic uopValid,
	input uopT uop,
	input logic [`BOTTOM_DATA_W-1:0] res,
	input logic [`BOTTOM_VECTOR_W-1:0] irqVector,
	output logic [`BOTTOM_ADDR_W-1:0] addr,
	output logic [`BOTTOM_DATA_W-1:0] aluOp1,
	output logic [`BOTTOM_DATA_W-1:0] aluOp2,
	output logic bq4,
	output logic bq5,
	output logic bq7,
	output flagsT tempFlags,
	output logic [`BOTTOM_DATA_W-1:0] ir
);

	ctrlT ctrl;

	logic [`BOTTOM_DATA_W-1:0] srcData;
	logic [`BOTTOM_DATA_W-1:0] aReg;
	logic [`BOTTOM_DATA_W-1:0] zReg;
	logic [`BOTTOM_ADDR_W-1:0] pairData;
	logic [`BOTTOM_ADDR_W-1:0] wzPair;
	logic [`BOTTOM_ADDR_W-1:0] stepped;

	// Writeback into the register file
	logic writeEn;
	logic zWriteEn;
	logic pairWriteEn;
	logic [`BOTTOM_DATA_W-1:0] writeData;
	logic [`BOTTOM_ADDR_W-1:0] pairWriteData;

	microDecode decode0 (
		.CLK(CLK),
		.rstN(rstN),
		.uopValid(uopValid),
		.uop(uop),
		.ctrl(ctrl)
	);

	registerFile regs0 (
		.CLK(CLK),
		.rstN(rstN),
		.ctrl(ctrl),
		.writeEn(writeEn),
		.writeData(writeData),
		.zWriteEn(zWriteEn),
		.pairWriteEn(pairWriteEn),
		.pairWriteData(pairWriteData),
		.srcData(srcData),
		.pairData(pairData),
		.wzPair(wzPair),
		.aReg(aReg),
		.zReg(zReg)
	);

	addressUnit addr0 (
		.CLK(CLK),
		.rstN(rstN),
		.ctrl(ctrl),
		.pairData(pairData),
		.wzPair(wzPair),
		.irqVector(irqVector),
		.addr(addr),
		.stepped(stepped)
	);

	operandShaper shaper0 (
		.ctrl(ctrl),
		.aReg(aReg),
		.srcData(srcData),
		.aluOp1(aluOp1),
		.aluOp2(aluOp2),
		.bq4(bq4),
		.bq5(bq5),
		.bq7(bq7)
	);

	resultWriteback result0 (
		.CLK(CLK),
		.rstN(rstN),
		.ctrl(ctrl),
		.srcData(srcData),
		.res(res),
		.stepped(stepped),
		.zReg(zReg),
		.writeEn(writeEn),
		.writeData(writeData),
		.zWriteEn(zWriteEn),
		.pairWriteEn(pairWriteEn),
		.pairWriteData(pairWriteData),
		.ir(ir),
		.tempFlags(tempFlags)
	);

endmodule

// ==== logic/resultWriteback.sv ====
`include "bottom_defines.svh"

module resultWriteback
	import bottomPkg::*;
(
	input logic CLK,
	input logic rstN,
	input ctrlT ctrl,
	input logic [`BOTTOM_DATA_W-1:0] srcData,
	input logic [`BOTTOM_DATA_W-1:0] res,
	input logic [`BOTTOM_ADDR_W-1:0] stepped,
	input logic [`BOTTOM_DATA_W-1:0] zReg,
	output logic writeEn,
	output logic [`BOTTOM_DATA_W-1:0] writeData,
	output logic zWriteEn,
	output logic pairWriteEn,
	output logic [`BOTTOM_ADDR_W-1:0] pairWriteData,
	output logic [`BOTTOM_DATA_W-1:0] ir,
	output flagsT tempFlags
);

	always_comb begin
		case (ctrl.kind)
			LOADIMM: writeData = ctrl.imm;
			MOVE: writeData = srcData;
			default: writeData = res;	// ALU result
		endcase
	end

	assign writeEn = (ctrl.kind == LOADIMM) || (ctrl.kind == MOVE) || (ctrl.kind == ALUOP);
	assign zWriteEn = (ctrl.kind == ALUOP);	// Z keeps a copy for the flags

	assign pairWriteEn = (ctrl.kind == PAIRSTEP);
	assign pairWriteData = stepped;

	always_ff @(posedge CLK or negedge rstN) begin
		if (!rstN) begin
			ir <= '0;
		end else if (ctrl.kind == FETCH) begin
			ir <= ctrl.imm;	// Opcode byte from the data bus
		end
	end

	assign tempFlags = '{z: zReg[7], n: zReg[6], h: zReg[5], c: zReg[4]};

endmodule

// ==== logic/operandShaper.sv ====
`include "bottom_defines.svh"

module operandShaper
	import bottomPkg::*;
(
	input ctrlT ctrl,
	input logic [`BOTTOM_DATA_W-1:0] aReg,
	input logic [`BOTTOM_DATA_W-1:0] srcData,
	output logic [`BOTTOM_DATA_W-1:0] aluOp1,
	output logic [`BOTTOM_DATA_W-1:0] aluOp2,
	output logic bq4,
	output logic bq5,
	output logic bq7
);

	logic aluCycle;
	logic [`BOTTOM_DATA_W-1:0] maskedSrc;

	assign aluCycle = (ctrl.kind == ALUOP);

	// Masked bits forced to zero
	assign maskedSrc = srcData & ~ctrl.mask;

	always_comb begin
		if (aluCycle) begin
			aluOp1 = aReg;
			aluOp2 = maskedSrc;
		end else begin
			aluOp1 = `BOTTOM_IDLE_OPERAND;	// Buses sit precharged
			aluOp2 = `BOTTOM_IDLE_OPERAND;
		end
	end

	// Accumulator status for the decoder
	assign bq4 = aReg[1] | aReg[2] | aReg[3];
	assign bq5 = aReg[5] | aReg[6] | aReg[7];
	assign bq7 = aReg[4] | aReg[7];

endmodule

// ==== logic/addressUnit.sv ====
`include "bottom_defines.svh"

module addressUnit
	import bottomPkg::*;
(
	input logic CLK,
	input logic rstN,
	input ctrlT ctrl,
	input logic [`BOTTOM_ADDR_W-1:0] pairData,
	input logic [`BOTTOM_ADDR_W-1:0] wzPair,
	input logic [`BOTTOM_VECTOR_W-1:0] irqVector,
	output logic [`BOTTOM_ADDR_W-1:0] addr,
	output logic [`BOTTOM_ADDR_W-1:0] stepped
);

	localparam int RestartPad = `BOTTOM_ADDR_W - `BOTTOM_VECTOR_W - 3;

	logic [`BOTTOM_ADDR_W-1:0] pc;
	logic [`BOTTOM_ADDR_W-1:0] stepIn;
	logic [`BOTTOM_ADDR_W-1:0] restartAddr;
	logic pairCycle;

	assign pairCycle = (ctrl.kind == PAIRSTEP);

	// Shared incrementer sees the pair on PAIRSTEP, the PC otherwise
	assign stepIn = pairCycle ? pairData : pc;

	always_comb begin
		if (pairCycle && ctrl.down) begin
			stepped = stepIn - 1'b1;	// Wraps 0000 to FFFF
		end else begin
			stepped = stepIn + 1'b1;
		end
	end

	// Vector times eight, zeros above
	assign restartAddr = {{RestartPad{1'b0}}, irqVector, 3'b000};

	// Address bus shows the pair only while it steps
	assign addr = stepIn;

	always_ff @(posedge CLK or negedge rstN) begin
		if (!rstN) begin
			pc <= '0;
		end else begin
			case (ctrl.kind)
				FETCH: begin
					pc <= stepped;
				end
				JUMP: begin
					pc <= wzPair;
				end
				RESTART: begin
					pc <= restartAddr;
				end
				default: begin
					pc <= pc;
				end
			endcase
		end
	end

endmodule

// ==== logic/registerFile.sv ====
`include "bottom_defines.svh"

module registerFile
	import bottomPkg::*;
(
	input logic CLK,
	input logic rstN,
	input ctrlT ctrl,
	input logic writeEn,
	input logic [`BOTTOM_DATA_W-1:0] writeData,
	input logic zWriteEn,
	input logic pairWriteEn,
	input logic [`BOTTOM_ADDR_W-1:0] pairWriteData,
	output logic [`BOTTOM_DATA_W-1:0] srcData,
	output logic [`BOTTOM_ADDR_W-1:0] pairData,
	output logic [`BOTTOM_ADDR_W-1:0] wzPair,
	output logic [`BOTTOM_DATA_W-1:0] aReg,
	output logic [`BOTTOM_DATA_W-1:0] zReg
);

	localparam int NumRegs = 11;

	logic [NumRegs-1:0][`BOTTOM_DATA_W-1:0] regs;
	regIdxT hiIdx;
	regIdxT loIdx;

	// Pair code to high and low slot
	always_comb begin
		case (ctrl.pairSel)
			2'd0: begin hiIdx = REG_B; loIdx = REG_C; end
			2'd1: begin hiIdx = REG_D; loIdx = REG_E; end
			2'd2: begin hiIdx = REG_H; loIdx = REG_L; end
			default: begin hiIdx = REG_SPH; loIdx = REG_SPL; end
		endcase
	end

	// Codes above SPL read as zero
	assign srcData = (ctrl.srcSel <= REG_SPL) ? regs[ctrl.srcSel] : '0;
	assign pairData = {regs[hiIdx], regs[loIdx]};
	assign wzPair = {regs[REG_W], regs[REG_Z]};
	assign aReg = regs[REG_A];
	assign zReg = regs[REG_Z];

	always_ff @(posedge CLK or negedge rstN) begin
		if (!rstN) begin
			regs <= '0;
		end else begin
			if (writeEn && (ctrl.writeSel <= REG_SPL)) begin
				regs[ctrl.writeSel] <= writeData;
			end
			if (zWriteEn) begin
				regs[REG_Z] <= writeData;	// ALU result copy into Z
			end
			if (pairWriteEn) begin
				regs[hiIdx] <= pairWriteData[`BOTTOM_ADDR_W-1:`BOTTOM_DATA_W];
				regs[loIdx] <= pairWriteData[`BOTTOM_DATA_W-1:0];
			end
		end
	end

endmodule

// ==== logic/microDecode.sv ====
module microDecode
	import bottomPkg::*;
(
	input logic CLK,
	input logic rstN,
	input logic uopValid,
	input uopT uop,
	output ctrlT ctrl
);

	// Control word that does nothing
	localparam ctrlT IdleCtrl = '{
		kind: NOP,
		writeSel: REG_B,
		srcSel: REG_B,
		pairSel: 2'b00,
		down: 1'b0,
		imm: '0,
		mask: '0
	};

	ctrlT decoded;

	// bc[4] blanks the whole operand and bc[0] enables the upper nibble clears
	function automatic logic [7:0] maskFromBc(input logic [5:0] bc);
		logic [7:0] m;
		m = {8{bc[4]}};
		if (bc[0]) begin
			m[7:4] = m[7:4] | {bc[3], bc[2], bc[5], bc[1]};
		end
		return m;
	endfunction

	always_comb begin
		decoded = IdleCtrl;
		decoded.kind = uop.kind;
		decoded.srcSel = uop.src;
		decoded.imm = uop.imm;
		decoded.mask = maskFromBc(uop.bc);

		case (uop.kind)
			ALUOP: begin
				decoded.writeSel = REG_A;	// Result always lands in A
			end
			PAIRSTEP: begin
				decoded.pairSel = uop.dst[1:0];
				decoded.down = uop.down;
			end
			default: begin
				decoded.writeSel = uop.dst;
			end
		endcase
	end

	always_ff @(posedge CLK or negedge rstN) begin
		if (!rstN) begin
			ctrl <= IdleCtrl;
		end else if (uopValid) begin
			ctrl <= decoded;
		end else begin
			ctrl <= IdleCtrl;	// Idle without a strobe
		end
	end

endmodule

// ==== logic/bottomPkg.sv ====
`include "bottom_defines.svh"

package bottomPkg;

	// Register file slots, SP halves last
	typedef enum logic [3:0] {
		REG_B = 4'd0,
		REG_C = 4'd1,
		REG_D = 4'd2,
		REG_E = 4'd3,
		REG_H = 4'd4,
		REG_L = 4'd5,
		REG_A = 4'd6,
		REG_W = 4'd7,
		REG_Z = 4'd8,
		REG_SPH = 4'd9,
		REG_SPL = 4'd10
	} regIdxT;

	typedef enum logic [2:0] {
		NOP = 3'd0,
		LOADIMM = 3'd1,
		MOVE = 3'd2,
		ALUOP = 3'd3,
		FETCH = 3'd4,
		PAIRSTEP = 3'd5,
		JUMP = 3'd6,
		RESTART = 3'd7
	} uopKindT;

	typedef struct packed {
		uopKindT kind;
		regIdxT dst;			// Low two bits pick the pair on PAIRSTEP
		regIdxT src;
		logic [`BOTTOM_DATA_W-1:0] imm;	// Data bus byte, opcode on FETCH
		logic down;			// Decrement on PAIRSTEP
		logic [5:0] bc;			// Operand mask controls
	} uopT;

	typedef struct packed {
		uopKindT kind;
		regIdxT writeSel;
		regIdxT srcSel;
		logic [1:0] pairSel;		// BC, DE, HL, SP
		logic down;
		logic [`BOTTOM_DATA_W-1:0] imm;
		logic [`BOTTOM_DATA_W-1:0] mask;	// Set bit clears the operand bit
	} ctrlT;

	// Flags as held in the upper nibble of Z
	typedef struct packed {
		logic z;
		logic n;
		logic h;
		logic c;
	} flagsT;

endpackage

// ==== logic/bottom_defines.svh ====
`ifndef BOTTOM_DEFINES_SVH
`define BOTTOM_DEFINES_SVH

// Register and data bus width
`define BOTTOM_DATA_W 8

// External address bus width
`define BOTTOM_ADDR_W 16

// Precharged bus level seen on the ALU inputs when idle
`define BOTTOM_IDLE_OPERAND {`BOTTOM_DATA_W{1'b1}}

// Restart vector from the interrupt logic
`define BOTTOM_VECTOR_W 5

`endif
